/* hw/caf_pkg.sv */
`default_nettype none

package caf_pkg;

   typedef logic [15:0]        sample_t;  // i in [15:8], q in [7:0]
   typedef logic signed [7:0]  comp_t;
   typedef logic [2:0]         phase_t;   // eighths of a turn
   typedef logic signed [23:0] acc_t;
   typedef logic [24:0]        mag_t;     // |re| + |im|

   localparam int rot_shift = 6;  // tables carry a gain of 64

   localparam comp_t rot_cos [8] = '{8'sd64, 8'sd45, 8'sd0, -8'sd45,
                                     -8'sd64, -8'sd45, 8'sd0, 8'sd45};
   localparam comp_t rot_sin [8] = '{8'sd0, 8'sd45, 8'sd64, 8'sd45,
                                     8'sd0, -8'sd45, -8'sd64, -8'sd45};

   typedef enum logic [2:0] {
      INIT,
      IDLE,
      LOAD_REF,
      LOAD_CAP,
      CORRELATE,
      FIND_MAX,
      REPORT
   } caf_state_t;

   function automatic comp_t sample_i(sample_t s);
      return comp_t'(s[15:8]);
   endfunction

   function automatic comp_t sample_q(sample_t s);
      return comp_t'(s[7:0]);
   endfunction

   function automatic sample_t make_sample(comp_t i, comp_t q);
      return {i, q};
   endfunction

   // L1 magnitude, -2^23 maps to 2^23 through the zero-extended bit pattern
   function automatic mag_t l1_mag(acc_t re, acc_t im);
      logic [23:0] a_re;
      logic [23:0] a_im;
      a_re = re[23] ? 24'(-re) : 24'(re);
      a_im = im[23] ? 24'(-im) : 24'(im);
      return {1'b0, a_re} + {1'b0, a_im};
   endfunction

endpackage

`default_nettype wire

/* hw/caf_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface caf_stream_if #(
   parameter int LAG_W  = 4,
   parameter int ADDR_W = 4
);
   import caf_pkg::*;

   logic              valid;
   logic              first;       // n == 0 of a lag
   logic              last;        // n == REF_LEN-1
   logic [LAG_W-1:0]  lag;
   logic [ADDR_W-1:0] cap_index;   // m = n + lag
   sample_t           ref_sample;
   sample_t           cap_sample;

   modport src       (output valid, first, last, lag, cap_index, ref_sample, cap_sample);
   modport shift_in  (input  valid, first, last, lag, cap_index, ref_sample, cap_sample);
   modport shift_out (output valid, first, last, lag, cap_index, ref_sample, cap_sample);
   modport sink      (input  valid, first, last, lag, cap_index, ref_sample, cap_sample);

endinterface

`default_nettype wire

/* hw/sample_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_buffer #(
   parameter  int DEPTH  = 16,
   localparam int addr_w = $clog2(DEPTH)
) (
   input  logic              clk,
   input  logic              we,
   input  logic [addr_w-1:0] addr,
   input  caf_pkg::sample_t  wdata,
   output caf_pkg::sample_t  rdata
);
   import caf_pkg::*;

   sample_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];  // old contents on a write cycle
   end

   a_wr_in_range: assert property (@(posedge clk)
      we |-> (int'(addr) < DEPTH));

endmodule

`default_nettype wire

/* hw/freq_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module freq_shift #(
   parameter int BIN = 0
) (
   input logic             clk,
   input logic             rst,
   caf_stream_if.shift_in  up,
   caf_stream_if.shift_out down
);
   import caf_pkg::*;

   phase_t                         ph;
   logic signed [15:0]             p_ic;
   logic signed [15:0]             p_qs;
   logic signed [15:0]             p_is;
   logic signed [15:0]             p_qc;
   logic signed [16:0]             re_full;
   logic signed [16:0]             im_full;
   logic                           v_1;
   logic                           first_1;
   logic                           last_1;
   logic [$bits(up.lag)-1:0]       lag_1;
   logic [$bits(up.cap_index)-1:0] idx_1;
   sample_t                        ref_1;

   // |re| can reach about 180 so clip back into a sample component
   function automatic comp_t sat8(logic signed [16:0] v);
      if (v > 17'sd127) begin
         return 8'sd127;
      end
      if (v < -17'sd128) begin
         return -8'sd128;
      end
      return comp_t'(v);
   endfunction

   assign ph = phase_t'(BIN * int'(up.cap_index));  // (b*m) mod 8

   // stage 1
   always_ff @(posedge clk) begin
      if (rst) begin
         v_1     <= 1'b0;
         first_1 <= 1'b0;
         last_1  <= 1'b0;
      end else begin
         v_1     <= up.valid;
         first_1 <= up.first;
         last_1  <= up.last;
      end
      p_ic  <= sample_i(up.cap_sample) * rot_cos[ph];
      p_qs  <= sample_q(up.cap_sample) * rot_sin[ph];
      p_is  <= sample_i(up.cap_sample) * rot_sin[ph];
      p_qc  <= sample_q(up.cap_sample) * rot_cos[ph];
      lag_1 <= up.lag;
      idx_1 <= up.cap_index;
      ref_1 <= up.ref_sample;
   end

   assign re_full = p_ic - p_qs;
   assign im_full = p_is + p_qc;

   // stage 2
   always_ff @(posedge clk) begin
      if (rst) begin
         down.valid <= 1'b0;
         down.first <= 1'b0;
         down.last  <= 1'b0;
      end else begin
         down.valid <= v_1;
         down.first <= first_1;
         down.last  <= last_1;
      end
      down.lag        <= lag_1;
      down.cap_index  <= idx_1;
      down.ref_sample <= ref_1;
      down.cap_sample <= make_sample(sat8(re_full >>> rot_shift),
                                     sat8(im_full >>> rot_shift));
   end

endmodule

`default_nettype wire

/* hw/x_corr.sv */
`timescale 1ns/1ps
`default_nettype none

module x_corr #(
   parameter  int REF_LEN = 8,
   parameter  int CAP_LEN = 16,
   localparam int lag_w   = $clog2(CAP_LEN - REF_LEN + 1)
) (
   input  logic             clk,
   input  logic             rst,
   caf_stream_if.sink       s,
   output logic             done,
   output caf_pkg::mag_t    peak_mag,
   output logic [lag_w-1:0] peak_lag
);
   import caf_pkg::*;

   localparam logic [lag_w-1:0] last_lag = lag_w'(CAP_LEN - REF_LEN);

   logic signed [16:0] prod_re;
   logic signed [16:0] prod_im;
   acc_t               acc_re;
   acc_t               acc_im;
   logic               fin;      // acc holds a finished lag
   logic [lag_w-1:0]   fin_lag;
   mag_t               mag;

   // cap * conj(ref)
   assign prod_re = sample_i(s.cap_sample) * sample_i(s.ref_sample)
                  + sample_q(s.cap_sample) * sample_q(s.ref_sample);
   assign prod_im = sample_q(s.cap_sample) * sample_i(s.ref_sample)
                  - sample_i(s.cap_sample) * sample_q(s.ref_sample);

   always_ff @(posedge clk) begin
      if (s.valid) begin
         if (s.first) begin
            acc_re <= acc_t'(prod_re);
            acc_im <= acc_t'(prod_im);
         end else begin
            acc_re <= acc_re + acc_t'(prod_re);
            acc_im <= acc_im + acc_t'(prod_im);
         end
      end
      fin_lag <= s.lag;
   end

   assign mag = l1_mag(acc_re, acc_im);

   always_ff @(posedge clk) begin
      if (rst) begin
         fin  <= 1'b0;
         done <= 1'b0;
      end else begin
         fin  <= s.valid && s.last;
         done <= fin && (fin_lag == last_lag);  // whole lag range scanned
      end
   end

   // strictly greater keeps the lower lag on a tie
   always_ff @(posedge clk) begin
      if (s.valid && s.first && s.lag == '0) begin
         peak_mag <= '0;
         peak_lag <= '0;
      end else if (fin && mag > peak_mag) begin
         peak_mag <= mag;
         peak_lag <= fin_lag;
      end
   end

   a_ctl_has_valid: assert property (@(posedge clk) disable iff (rst)
      (s.first || s.last) |-> s.valid);

endmodule

`default_nettype wire

/* hw/caf_control.sv */
`timescale 1ns/1ps
`default_nettype none

module caf_control #(
   parameter  int REF_LEN  = 8,
   parameter  int CAP_LEN  = 16,
   parameter  int NUM_BINS = 4,
   localparam int ref_w    = $clog2(REF_LEN),
   localparam int addr_w   = $clog2(CAP_LEN),
   localparam int lag_w    = $clog2(CAP_LEN - REF_LEN + 1),
   localparam int bin_w    = $clog2(NUM_BINS)
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           in_req,
   output logic                           in_ack,
   output logic                           ref_we,
   output logic                           cap_we,
   output logic [ref_w-1:0]               ref_addr,
   output logic [addr_w-1:0]              buf_addr,
   input  caf_pkg::sample_t               ref_rdata,
   input  caf_pkg::sample_t               cap_rdata,
   caf_stream_if.src                      raw,
   input  logic [NUM_BINS-1:0]            bin_done,
   input  caf_pkg::mag_t [NUM_BINS-1:0]   bin_mag,
   input  logic [NUM_BINS-1:0][lag_w-1:0] bin_lag,
   output logic                           res_req,
   input  logic                           res_ack,
   output logic [bin_w-1:0]               best_bin,
   output logic [lag_w-1:0]               best_lag,
   output caf_pkg::mag_t                  best_mag
);
   import caf_pkg::*;

   localparam int num_lags = CAP_LEN - REF_LEN + 1;

   caf_state_t          state;
   logic [addr_w-1:0]   ld_cnt;
   logic                wr_en;
   logic                rd_on;      // read sequencer running
   logic [ref_w-1:0]    rd_n;
   logic [lag_w-1:0]    rd_lag;
   logic [NUM_BINS-1:0] done_seen;
   logic [bin_w-1:0]    scan;

   assign wr_en  = (state == LOAD_REF || state == LOAD_CAP) && in_req && !in_ack;
   assign ref_we = wr_en && (state == LOAD_REF);
   assign cap_we = wr_en && (state == LOAD_CAP);

   assign ref_addr = (state == LOAD_REF) ? ref_w'(ld_cnt) : rd_n;
   assign buf_addr = (state == LOAD_CAP) ? ld_cnt : addr_w'(rd_n) + addr_w'(rd_lag);

   assign raw.ref_sample = ref_rdata;
   assign raw.cap_sample = cap_rdata;

   // controls lag the address by the RAM read cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         raw.valid <= 1'b0;
         raw.first <= 1'b0;
         raw.last  <= 1'b0;
      end else begin
         raw.valid <= rd_on;
         raw.first <= rd_on && (rd_n == '0);
         raw.last  <= rd_on && (rd_n == ref_w'(REF_LEN - 1));
      end
      raw.lag       <= rd_lag;
      raw.cap_index <= buf_addr;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= INIT;
         in_ack    <= 1'b0;
         res_req   <= 1'b0;
         ld_cnt    <= '0;
         rd_on     <= 1'b0;
         rd_n      <= '0;
         rd_lag    <= '0;
         done_seen <= '0;
         scan      <= '0;
      end else begin
         if (in_ack && !in_req) begin
            in_ack <= 1'b0;
         end else if (wr_en) begin
            in_ack <= 1'b1;
         end

         if (rd_on) begin
            if (rd_n == ref_w'(REF_LEN - 1)) begin
               rd_n   <= '0;
               rd_lag <= rd_lag + 1'b1;
               if (rd_lag == lag_w'(num_lags - 1)) begin
                  rd_on <= 1'b0;
               end
            end else begin
               rd_n <= rd_n + 1'b1;
            end
         end

         done_seen <= done_seen | bin_done;

         case (state)
            INIT: begin
               ld_cnt <= '0;
               state  <= IDLE;
            end
            IDLE: begin
               if (in_req) begin
                  ld_cnt <= '0;
                  state  <= LOAD_REF;
               end
            end
            LOAD_REF: begin
               if (wr_en) begin
                  if (ld_cnt == addr_w'(REF_LEN - 1)) begin
                     ld_cnt <= '0;
                     state  <= LOAD_CAP;
                  end else begin
                     ld_cnt <= ld_cnt + 1'b1;
                  end
               end
            end
            LOAD_CAP: begin
               if (wr_en) begin
                  if (ld_cnt == addr_w'(CAP_LEN - 1)) begin
                     rd_on     <= 1'b1;
                     rd_n      <= '0;
                     rd_lag    <= '0;
                     done_seen <= '0;
                     state     <= CORRELATE;
                  end else begin
                     ld_cnt <= ld_cnt + 1'b1;
                  end
               end
            end
            CORRELATE: begin
               if (&done_seen) begin
                  scan  <= '0;
                  state <= FIND_MAX;
               end
            end
            FIND_MAX: begin
               if (scan == bin_w'(NUM_BINS - 1)) begin
                  res_req <= 1'b1;
                  state   <= REPORT;
               end else begin
                  scan <= scan + 1'b1;
               end
            end
            REPORT: begin
               if (res_req && res_ack) begin
                  res_req <= 1'b0;
               end else if (!res_req && !res_ack) begin
                  state <= IDLE;
               end
            end
            default: state <= INIT;
         endcase
      end
   end

   // bins scanned in order, lower bin wins a tie
   always_ff @(posedge clk) begin
      if (state == FIND_MAX && (scan == '0 || bin_mag[scan] > best_mag)) begin
         best_bin <= scan;
         best_lag <= bin_lag[scan];
         best_mag <= bin_mag[scan];
      end
   end

   a_res_hold: assert property (@(posedge clk) disable iff (rst)
      (res_req && !res_ack) |=> res_req);

endmodule

`default_nettype wire

/* hw/caf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module caf_top #(
   parameter  int REF_LEN  = 8,
   parameter  int CAP_LEN  = 16,
   parameter  int NUM_BINS = 4,
   localparam int lag_w    = $clog2(CAP_LEN - REF_LEN + 1),
   localparam int bin_w    = $clog2(NUM_BINS)
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             in_req,
   input  caf_pkg::sample_t in_data,
   output logic             in_ack,
   output logic             res_req,
   input  logic             res_ack,
   output logic [bin_w-1:0] best_bin,
   output logic [lag_w-1:0] best_lag,
   output caf_pkg::mag_t    best_mag
);
   import caf_pkg::*;

   localparam int ref_w  = $clog2(REF_LEN);
   localparam int addr_w = $clog2(CAP_LEN);

   logic                           ref_we;
   logic                           cap_we;
   logic [ref_w-1:0]               ref_addr;
   logic [addr_w-1:0]              buf_addr;
   sample_t                        ref_rdata;
   sample_t                        cap_rdata;
   logic [NUM_BINS-1:0]            bin_done;
   mag_t [NUM_BINS-1:0]            bin_mag;
   logic [NUM_BINS-1:0][lag_w-1:0] bin_lag;

   caf_stream_if #(.LAG_W(lag_w), .ADDR_W(addr_w)) raw_if ();

   sample_buffer #(.DEPTH(REF_LEN)) u_ref_buf (
      .clk   (clk),
      .we    (ref_we),
      .addr  (ref_addr),
      .wdata (in_data),
      .rdata (ref_rdata)
   );

   sample_buffer #(.DEPTH(CAP_LEN)) u_cap_buf (
      .clk   (clk),
      .we    (cap_we),
      .addr  (buf_addr),
      .wdata (in_data),
      .rdata (cap_rdata)
   );

   caf_control #(
      .REF_LEN  (REF_LEN),
      .CAP_LEN  (CAP_LEN),
      .NUM_BINS (NUM_BINS)
   ) u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .in_req    (in_req),
      .in_ack    (in_ack),
      .ref_we    (ref_we),
      .cap_we    (cap_we),
      .ref_addr  (ref_addr),
      .buf_addr  (buf_addr),
      .ref_rdata (ref_rdata),
      .cap_rdata (cap_rdata),
      .raw       (raw_if.src),
      .bin_done  (bin_done),
      .bin_mag   (bin_mag),
      .bin_lag   (bin_lag),
      .res_req   (res_req),
      .res_ack   (res_ack),
      .best_bin  (best_bin),
      .best_lag  (best_lag),
      .best_mag  (best_mag)
   );

   // one shifter and correlator per frequency bin
   for (genvar b = 0; b < NUM_BINS; b++) begin : g_bin
      caf_stream_if #(.LAG_W(lag_w), .ADDR_W(addr_w)) sh_if ();

      freq_shift #(.BIN(b)) u_shift (
         .clk  (clk),
         .rst  (rst),
         .up   (raw_if.shift_in),
         .down (sh_if.shift_out)
      );

      x_corr #(.REF_LEN(REF_LEN), .CAP_LEN(CAP_LEN)) u_corr (
         .clk      (clk),
         .rst      (rst),
         .s        (sh_if.sink),
         .done     (bin_done[b]),
         .peak_mag (bin_mag[b]),
         .peak_lag (bin_lag[b])
      );
   end

endmodule

`default_nettype wire

/* testbench/caf_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module caf_clock_gen #(
   parameter int HALF_PERIOD  = 50,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;  // 100 ns period
   end

   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

/* testbench/caf_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module caf_checker #(
   parameter  int REF_LEN    = 8,
   parameter  int CAP_LEN    = 16,
   parameter  int NUM_BINS   = 4,
   parameter  int NUM_FRAMES = 20,
   localparam int lag_w      = $clog2(CAP_LEN - REF_LEN + 1),
   localparam int bin_w      = $clog2(NUM_BINS)
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             in_req,
   input  logic             in_ack,
   input  logic             res_req,
   output logic             res_ack,
   input  logic [bin_w-1:0] best_bin,
   input  logic [lag_w-1:0] best_lag,
   input  caf_pkg::mag_t    best_mag,
   input  logic             exp_push,
   input  logic [1:0]       exp_kind,
   input  logic [bin_w-1:0] exp_bin,
   input  logic [lag_w-1:0] exp_lag,
   input  caf_pkg::mag_t    exp_mag,
   output int               err_count,
   output int               tests_done,
   output logic             timed_out
);

   localparam int cycles_per_frame = 2000;
   localparam int timeout_cycles   = NUM_FRAMES * cycles_per_frame;
   localparam int acks_per_frame   = REF_LEN + CAP_LEN;

   typedef enum logic [1:0] {R_IDLE, R_DELAY, R_ACK} res_state_t;

   res_state_t r_state;
   int         seed = 32'h9a19_25f4;
   int         q_kind [$];
   int         q_bin [$];
   int         q_lag [$];
   int         q_mag [$];
   int         errs;
   int         done_n;
   int         cycles;
   int         ack_cnt;
   int         delay;
   int         got_bin;
   int         got_lag;
   int         got_mag;
   logic       ack_d;
   logic       pending;     // frame fully taken, result not yet exchanged
   logic       rst_checked;
   logic       held_bad;

   function automatic string test_name(int kind);
      case (kind)
         1: return "pure_delay";
         2: return "freq_offset";
         3: return "random_frame";
         default: return "unknown";
      endcase
   endfunction

   task automatic protocol_error(string what);
      $display("protocol failure at cycle %0d: %s", cycles, what);
      errs++;
   endtask

   task automatic compare_result();
      int e_kind;
      int e_bin;
      int e_lag;
      int e_mag;
      if (ack_cnt != acks_per_frame) begin
         protocol_error($sformatf("frame took %0d input acks instead of %0d",
                                  ack_cnt, acks_per_frame));
      end
      if (q_kind.size() == 0) begin
         protocol_error("res_req rose with no frame outstanding");
      end else begin
         e_kind = q_kind.pop_front();
         e_bin  = q_bin.pop_front();
         e_lag  = q_lag.pop_front();
         e_mag  = q_mag.pop_front();
         if (got_bin != e_bin || got_lag != e_lag || got_mag != e_mag) begin
            $display("ERROR %s frame %0d expected bin %0d lag %0d mag %0d actual bin %0d lag %0d mag %0d",
                     test_name(e_kind), done_n, e_bin, e_lag, e_mag, got_bin, got_lag, got_mag);
            errs++;
         end else begin
            $display("PASS %s frame %0d bin %0d lag %0d mag %0d",
                     test_name(e_kind), done_n, got_bin, got_lag, got_mag);
         end
      end
      done_n++;
   endtask

   task automatic verify_hold();
      if (!held_bad && (int'(best_bin) != got_bin || int'(best_lag) != got_lag ||
                        int'(best_mag) != got_mag)) begin
         protocol_error("result outputs changed while res_req was high");
         held_bad = 1'b1;
      end
   endtask

   initial begin
      res_ack    = 1'b0;
      timed_out  = 1'b0;
      err_count  = 0;
      tests_done = 0;
   end

   always @(posedge clk) begin
      if (rst) begin
         r_state     = R_IDLE;
         errs        = 0;
         done_n      = 0;
         cycles      = 0;
         ack_cnt     = 0;
         ack_d       = 1'b0;
         pending     = 1'b0;
         rst_checked = 1'b0;
         res_ack <= 1'b0;
      end else begin
         cycles++;
         if (cycles == timeout_cycles) begin
            $display("timeout after %0d cycles with %0d of %0d results received",
                     cycles, done_n, NUM_FRAMES);
            timed_out <= 1'b1;
         end
         if (exp_push) begin
            q_kind.push_back(int'(exp_kind));
            q_bin.push_back(int'(exp_bin));
            q_lag.push_back(int'(exp_lag));
            q_mag.push_back(int'(exp_mag));
         end
         if (!rst_checked) begin
            rst_checked = 1'b1;
            if (in_ack || res_req) begin
               protocol_error("in_ack or res_req high right after reset");
            end
         end
         if (in_ack && !ack_d) begin
            if (!in_req) begin
               protocol_error("in_ack rose without in_req");
            end
            if (pending) begin
               protocol_error("in_ack rose while a result was pending");
            end
            ack_cnt++;
            if (ack_cnt == acks_per_frame) begin
               pending = 1'b1;
            end
         end
         ack_d = in_ack;
         case (r_state)
            R_IDLE: begin
               if (res_req) begin
                  got_bin  = int'(best_bin);
                  got_lag  = int'(best_lag);
                  got_mag  = int'(best_mag);
                  held_bad = 1'b0;
                  compare_result();
                  delay   = int'($unsigned($random(seed)) % 6);
                  r_state = R_DELAY;
               end
            end
            R_DELAY: begin
               if (!res_req) begin
                  protocol_error("res_req fell before res_ack rose");
                  r_state = R_IDLE;
               end else begin
                  verify_hold();
                  if (delay == 0) begin
                     res_ack <= 1'b1;
                     r_state = R_ACK;
                  end else begin
                     delay--;
                  end
               end
            end
            R_ACK: begin
               if (res_req) begin
                  verify_hold();
               end else begin
                  res_ack <= 1'b0;
                  pending = 1'b0;
                  ack_cnt = 0;
                  r_state = R_IDLE;
               end
            end
            default: r_state = R_IDLE;
         endcase
         err_count  <= errs;
         tests_done <= done_n;
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_caf.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_caf;
   import caf_pkg::*;

   localparam int REF_LEN    = 8;
   localparam int CAP_LEN    = 16;
   localparam int NUM_BINS   = 4;
   localparam int NUM_FRAMES = 20;
   localparam int lag_w      = $clog2(CAP_LEN - REF_LEN + 1);
   localparam int bin_w      = $clog2(NUM_BINS);

   logic             clk;
   logic             rst;
   logic             in_req;
   sample_t          in_data;
   logic             in_ack;
   logic             res_req;
   logic             res_ack;
   logic [bin_w-1:0] best_bin;
   logic [lag_w-1:0] best_lag;
   mag_t             best_mag;
   logic             exp_push;
   logic [1:0]       exp_kind;
   logic [bin_w-1:0] exp_bin;
   logic [lag_w-1:0] exp_lag;
   mag_t             exp_mag;
   int               err_count;
   int               tests_done;
   logic             timed_out;
   int               seed = 32'h9a19_25f4;
   int               ref_i [REF_LEN];
   int               ref_q [REF_LEN];
   int               cap_i [CAP_LEN];
   int               cap_q [CAP_LEN];

   caf_clock_gen u_clk (.clk(clk), .rst(rst));

   caf_top #(.REF_LEN(REF_LEN), .CAP_LEN(CAP_LEN), .NUM_BINS(NUM_BINS)) UUT (
      .clk      (clk),
      .rst      (rst),
      .in_req   (in_req),
      .in_data  (in_data),
      .in_ack   (in_ack),
      .res_req  (res_req),
      .res_ack  (res_ack),
      .best_bin (best_bin),
      .best_lag (best_lag),
      .best_mag (best_mag)
   );

   caf_checker #(
      .REF_LEN    (REF_LEN),
      .CAP_LEN    (CAP_LEN),
      .NUM_BINS   (NUM_BINS),
      .NUM_FRAMES (NUM_FRAMES)
   ) u_chk (
      .clk        (clk),
      .rst        (rst),
      .in_req     (in_req),
      .in_ack     (in_ack),
      .res_req    (res_req),
      .res_ack    (res_ack),
      .best_bin   (best_bin),
      .best_lag   (best_lag),
      .best_mag   (best_mag),
      .exp_push   (exp_push),
      .exp_kind   (exp_kind),
      .exp_bin    (exp_bin),
      .exp_lag    (exp_lag),
      .exp_mag    (exp_mag),
      .err_count  (err_count),
      .tests_done (tests_done),
      .timed_out  (timed_out)
   );

   function automatic int rand_range(int lo, int hi);
      return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   function automatic int clip8(int v);
      if (v > 127) begin
         return 127;
      end
      if (v < -128) begin
         return -128;
      end
      return v;
   endfunction

   // one component of (i + jq) turned by ph eighths, gain of 64 removed
   function automatic int rotate_part(int i, int q, int ph, bit imag);
      if (imag) begin
         return clip8((i * rot_sin[ph] + q * rot_cos[ph]) >>> 6);
      end
      return clip8((i * rot_cos[ph] - q * rot_sin[ph]) >>> 6);
   endfunction

   // kind 1 delayed copy, 2 copy with frequency offset, 3 random
   task automatic build_frame(int kind, int amp);
      int lag;
      int bin;
      int noise;
      int ph;
      lag   = rand_range(0, CAP_LEN - REF_LEN);
      bin   = (kind == 2) ? rand_range(0, NUM_BINS - 1) : 0;
      noise = (kind == 1) ? 4 : 0;
      for (int n = 0; n < REF_LEN; n++) begin
         ref_i[n] = clip8(rand_range(-amp, amp));
         ref_q[n] = clip8(rand_range(-amp, amp));
      end
      for (int m = 0; m < CAP_LEN; m++) begin
         cap_i[m] = (kind == 3) ? clip8(rand_range(-amp, amp)) : rand_range(-noise, noise);
         cap_q[m] = (kind == 3) ? clip8(rand_range(-amp, amp)) : rand_range(-noise, noise);
      end
      if (kind != 3) begin
         for (int n = 0; n < REF_LEN; n++) begin
            ph = (8 - (bin * (n + lag)) % 8) % 8;  // undo the bin's turn
            cap_i[n + lag] = clip8(cap_i[n + lag] + rotate_part(ref_i[n], ref_q[n], ph, 1'b0));
            cap_q[n + lag] = clip8(cap_q[n + lag] + rotate_part(ref_i[n], ref_q[n], ph, 1'b1));
         end
      end
   endtask

   // first maximum in bin order, then lag order
   task automatic run_model(output int eb, output int el, output int em);
      int acc_re;
      int acc_im;
      int si;
      int sq;
      int ph;
      int mag;
      eb = 0;
      el = 0;
      em = -1;
      for (int b = 0; b < NUM_BINS; b++) begin
         for (int lag = 0; lag <= CAP_LEN - REF_LEN; lag++) begin
            acc_re = 0;
            acc_im = 0;
            for (int n = 0; n < REF_LEN; n++) begin
               ph = (b * (n + lag)) % 8;
               si = rotate_part(cap_i[n + lag], cap_q[n + lag], ph, 1'b0);
               sq = rotate_part(cap_i[n + lag], cap_q[n + lag], ph, 1'b1);
               acc_re += si * ref_i[n] + sq * ref_q[n];
               acc_im += sq * ref_i[n] - si * ref_q[n];
            end
            mag = (acc_re < 0 ? -acc_re : acc_re) + (acc_im < 0 ? -acc_im : acc_im);
            if (mag > em) begin
               em = mag;
               eb = b;
               el = lag;
            end
         end
      end
   endtask

   task automatic handshake_sample(int si, int sq);
      in_req  <= 1'b1;
      in_data <= {8'(si), 8'(sq)};
      @(posedge clk);
      while (!in_ack) @(posedge clk);
      in_req <= 1'b0;
      @(posedge clk);
      while (in_ack) @(posedge clk);
      repeat (rand_range(0, 2)) @(posedge clk);
   endtask

   task automatic drive_frame(int kind, int amp);
      int eb;
      int el;
      int em;
      build_frame(kind, amp);
      run_model(eb, el, em);
      exp_push <= 1'b1;
      exp_kind <= 2'(kind);
      exp_bin  <= bin_w'(eb);
      exp_lag  <= lag_w'(el);
      exp_mag  <= mag_t'(em);
      @(posedge clk);
      exp_push <= 1'b0;
      for (int n = 0; n < REF_LEN; n++) begin
         handshake_sample(ref_i[n], ref_q[n]);
      end
      for (int m = 0; m < CAP_LEN; m++) begin
         handshake_sample(cap_i[m], cap_q[m]);
      end
   endtask

   initial begin
      in_req   = 1'b0;
      in_data  = '0;
      exp_push = 1'b0;
      exp_kind = '0;
      exp_bin  = '0;
      exp_lag  = '0;
      exp_mag  = '0;
      @(posedge clk);
      while (rst) @(posedge clk);
      // next frame starts while the previous result is still pending
      for (int f = 0; f < NUM_FRAMES; f++) begin
         if (f < 6) begin
            drive_frame(1, 100);
         end else if (f < 12) begin
            drive_frame(2, 80);
         end else if (f < 18) begin
            drive_frame(3, 128);
         end else begin
            drive_frame(3, 19 - f);  // tiny and all-zero frames force ties
         end
      end
      while (tests_done < NUM_FRAMES) @(posedge clk);
      repeat (4) @(posedge clk);
      $display("tests %0d, errors %0d", tests_done, err_count);
      if (err_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   always @(posedge clk) begin
      if (timed_out) begin
         $display("ERRORS FOUND");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* filelist.f */
hw/caf_pkg.sv
hw/caf_stream_if.sv
hw/sample_buffer.sv
hw/freq_shift.sv
hw/x_corr.sv
hw/caf_control.sv
hw/caf_top.sv
testbench/caf_clock_gen.sv
testbench/caf_checker.sv
testbench/tb_caf.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_caf -f filelist.f --Mdir obj_dir -o sim_caf

./obj_dir/sim_caf 2>&1 | tee "$log"

if grep -q "ERRORS FOUND" "$log"; then
   echo "simulation failed, see $log"
   exit 1
fi
echo "simulation passed"
